// ==== design/histPkg.sv ====
package histPkg;

    // bin index width and bins per pixel histogram
    localparam int binBits = 4;
    localparam int binNum = 16;

    // pixels visited in one acquisition sweep
    localparam int pixelNum = 4;
    localparam int pixelBits = 2;

    // samples per pixel before moving on
    localparam int samplesPerPixel = 3;
    localparam int sampleBits = 2;

    // sweeps that make one frame
    localparam int acqNum = 6;
    localparam int acqBits = 3;

    // 18 samples per pixel per frame fit easily
    localparam int countBits = 8;

    // peak window half-width, in bins
    localparam int windowHalf = 2;

    // bin index of a sample or a peak
    typedef logic [binBits-1:0] binIdxT;

    // pixel currently being filled
    typedef logic [pixelBits-1:0] pixelIdxT;

    // occupancy of one bin
    typedef logic [countBits-1:0] countT;

    // highest bin and full window width, as bin indices
    localparam binIdxT lastBin = binIdxT'(binNum - 1);
    localparam binIdxT windowSpan = binIdxT'(2 * windowHalf);

    // sequencer states
    // collect takes samples, the two drain states let the frame results settle
    typedef enum logic [1:0] {
        collect = 2'd0,
        drain1 = 2'd1,
        drain2 = 2'd2
    } seqStateT;

endpackage

// ==== design/histSequencer.sv ====
`timescale 1ns/10ps

module histSequencer (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    output logic              sampleAccept,
    output histPkg::pixelIdxT pixel,
    output logic              frameDone,
    output logic              frameParity
);

    histPkg::seqStateT state;

    // position inside the pixel, and the acquisition sweep
    logic [histPkg::sampleBits-1:0] sampleCnt;
    logic [histPkg::acqBits-1:0] acqCnt;

    // wrap conditions of the nested counters
    logic pixelEnd;
    logic sweepEnd;
    logic frameEnd;

    // strobes only count while collecting
    assign sampleAccept = wrEn && (state == histPkg::collect);

    // innermost counter wraps after samplesPerPixel samples
    assign pixelEnd = (sampleCnt == histPkg::samplesPerPixel - 1);
    // last sample of the last pixel closes a sweep
    assign sweepEnd = pixelEnd && (pixel == histPkg::pixelNum - 1);
    // last sweep of the frame
    assign frameEnd = sweepEnd && (acqCnt == histPkg::acqNum - 1);

    // nested sample, pixel and acquisition counters
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel <= '0;
            acqCnt <= '0;
        end else if (sampleAccept) begin
            if (pixelEnd) begin
                sampleCnt <= '0;
                // next pixel, or back to pixel 0 after the sweep
                if (sweepEnd) begin
                    pixel <= '0;
                    // acquisition wraps on the frame's last sample
                    if (frameEnd) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // frame end pulse, parity and drain walk
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= histPkg::collect;
            frameDone <= 1'b0;
            frameParity <= 1'b0;
        end else begin
            // one-cycle pulse by default
            frameDone <= 1'b0;
            case (state)
                histPkg::collect: begin
                    if (sampleAccept && frameEnd) begin
                        frameDone <= 1'b1;
                        frameParity <= ~frameParity;
                        state <= histPkg::drain1;
                    end
                end
                // memory clears and peaks get handed over here
                histPkg::drain1: state <= histPkg::drain2;
                // window results latched, maxima cleared
                histPkg::drain2: state <= histPkg::collect;
                default: state <= histPkg::collect;
            endcase
        end
    end

endmodule

// ==== design/binMemory.sv ====
`timescale 1ns/10ps

module binMemory (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              sampleAccept,
    input  histPkg::pixelIdxT pixel,
    input  histPkg::binIdxT   addr,
    input  logic              frameDone,
    output histPkg::countT    binCount,
    output logic              countValid,
    output histPkg::pixelIdxT countPixel,
    output histPkg::binIdxT   countBin
);

    // one count per pixel and bin
    histPkg::countT mem [histPkg::pixelNum][histPkg::binNum];

    // incremented value of the addressed bin
    histPkg::countT nextCount;

    assign nextCount = mem[pixel][addr] + 1'b1;

    // histogram store
    // zero after reset and again after every frame
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                for (int b = 0; b < histPkg::binNum; b++) begin
                    mem[p][b] <= '0;
                end
            end
        end else if (frameDone) begin
            // frame clear, the whole array in one edge
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                for (int b = 0; b < histPkg::binNum; b++) begin
                    mem[p][b] <= '0;
                end
            end
        end else if (sampleAccept) begin
            mem[pixel][addr] <= nextCount;
        end
    end

    // new count with its pixel and bin, valid the cycle after acceptance
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binCount <= '0;
            countValid <= 1'b0;
            countPixel <= '0;
            countBin <= '0;
        end else begin
            countValid <= sampleAccept;
            // hold the last reported count between samples
            if (sampleAccept) begin
                binCount <= nextCount;
                countPixel <= pixel;
                countBin <= addr;
            end
        end
    end

endmodule

// ==== design/peakTracker.sv ====
`timescale 1ns/10ps

module peakTracker (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      countValid,
    input  histPkg::countT                            binCount,
    input  histPkg::pixelIdxT                         countPixel,
    input  histPkg::binIdxT                           countBin,
    input  logic                                      frameDone,
    output histPkg::countT  [histPkg::pixelNum-1:0]   maxCount,
    output histPkg::binIdxT [histPkg::pixelNum-1:0]   maxBin,
    output logic                                      peaksReady
);

    // strictly greater only
    // ties keep the bin that got there first
    logic newMax;

    assign newMax = countValid && (binCount > maxCount[countPixel]);

    // frameDone delayed one edge
    // final sample's count is folded in by then
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peaksReady <= 1'b0;
        end else begin
            peaksReady <= frameDone;
        end
    end

    // running maximum per pixel
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCount <= '0;
            maxBin <= '0;
        end else if (peaksReady) begin
            // results are taken on this same edge, start the next frame empty
            maxCount <= '0;
            maxBin <= '0;
        end else if (newMax) begin
            maxCount[countPixel] <= binCount;
            maxBin[countPixel] <= countBin;
        end
    end

endmodule

// ==== design/windowCalc.sv ====
`timescale 1ns/10ps

module windowCalc (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      peaksReady,
    input  histPkg::countT  [histPkg::pixelNum-1:0]   maxCount,
    input  histPkg::binIdxT [histPkg::pixelNum-1:0]   maxBin,
    output histPkg::binIdxT [histPkg::pixelNum-1:0]   peakBin,
    output histPkg::countT  [histPkg::pixelNum-1:0]   peakCount,
    output histPkg::binIdxT [histPkg::pixelNum-1:0]   windowLow,
    output histPkg::binIdxT [histPkg::pixelNum-1:0]   windowHigh,
    output logic                                      peakValid
);

    // window bounds before latching
    histPkg::binIdxT [histPkg::pixelNum-1:0] lowNext;
    histPkg::binIdxT [histPkg::pixelNum-1:0] highNext;

    // centred window, pushed inside the bin range at either edge
    always_comb begin
        for (int p = 0; p < histPkg::pixelNum; p++) begin
            if (maxBin[p] < histPkg::windowHalf) begin
                // near bin 0
                lowNext[p] = '0;
                highNext[p] = histPkg::windowSpan;
            end else if (maxBin[p] > histPkg::lastBin - histPkg::windowHalf) begin
                // near the top bin
                lowNext[p] = histPkg::lastBin - histPkg::windowSpan;
                highNext[p] = histPkg::lastBin;
            end else begin
                lowNext[p] = maxBin[p] - histPkg::binIdxT'(histPkg::windowHalf);
                highNext[p] = maxBin[p] + histPkg::binIdxT'(histPkg::windowHalf);
            end
        end
    end

    // frame results, held until the next frame end
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakBin <= '0;
            peakCount <= '0;
            windowLow <= '0;
            windowHigh <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= peaksReady;
            if (peaksReady) begin
                peakBin <= maxBin;
                peakCount <= maxCount;
                windowLow <= lowNext;
                windowHigh <= highNext;
            end
        end
    end

endmodule

// ==== design/histTop.sv ====
`timescale 1ns/10ps

module histTop (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      wrEn,
    input  histPkg::binIdxT                           addr,
    output histPkg::countT                            binCount,
    output logic                                      countValid,
    output logic                                      frameParity,
    output logic                                      peakValid,
    output histPkg::binIdxT [histPkg::pixelNum-1:0]   peakBin,
    output histPkg::countT  [histPkg::pixelNum-1:0]   peakCount,
    output histPkg::binIdxT [histPkg::pixelNum-1:0]   windowLow,
    output histPkg::binIdxT [histPkg::pixelNum-1:0]   windowHigh
);

    // sequencer to memory
    logic sampleAccept;
    histPkg::pixelIdxT pixel;
    logic frameDone;

    // count stream tags for the peak search
    histPkg::pixelIdxT countPixel;
    histPkg::binIdxT countBin;

    // running maxima into the window stage
    histPkg::countT [histPkg::pixelNum-1:0] maxCount;
    histPkg::binIdxT [histPkg::pixelNum-1:0] maxBin;
    logic peaksReady;

    // nested counters, frame end and drain
    histSequencer uSequencer (
        .clk          (clk),
        .combin_res   (combin_res),
        .wrEn         (wrEn),
        .sampleAccept (sampleAccept),
        .pixel        (pixel),
        .frameDone    (frameDone),
        .frameParity  (frameParity)
    );

    // per-pixel histograms
    binMemory uBinMemory (
        .clk          (clk),
        .combin_res   (combin_res),
        .sampleAccept (sampleAccept),
        .pixel        (pixel),
        .addr         (addr),
        .frameDone    (frameDone),
        .binCount     (binCount),
        .countValid   (countValid),
        .countPixel   (countPixel),
        .countBin     (countBin)
    );

    // most-populated bin per pixel
    peakTracker uPeakTracker (
        .clk        (clk),
        .combin_res (combin_res),
        .countValid (countValid),
        .binCount   (binCount),
        .countPixel (countPixel),
        .countBin   (countBin),
        .frameDone  (frameDone),
        .maxCount   (maxCount),
        .maxBin     (maxBin),
        .peaksReady (peaksReady)
    );

    // frame results and clamped windows
    windowCalc uWindowCalc (
        .clk        (clk),
        .combin_res (combin_res),
        .peaksReady (peaksReady),
        .maxCount   (maxCount),
        .maxBin     (maxBin),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .windowLow  (windowLow),
        .windowHigh (windowHigh),
        .peakValid  (peakValid)
    );

endmodule

// ==== bench/histModel.svh ====
// reference histograms, pixel then bin
int histRef [histPkg::pixelNum][histPkg::binNum];

// strict-greater running peak per pixel
int peakCountRef [histPkg::pixelNum];
int peakBinRef [histPkg::pixelNum];

// position inside the frame, innermost first
int samplePos;
int pixelPos;
int acqPos;
logic parityRef;

// empty histograms and peaks, as at a frame start
task automatic clearHistograms();
    for (int p = 0; p < histPkg::pixelNum; p++) begin
        peakCountRef[p] = 0;
        peakBinRef[p] = 0;
        for (int b = 0; b < histPkg::binNum; b++) begin
            histRef[p][b] = 0;
        end
    end
endtask

// one sample into the current pixel, then advance the nested counters
task automatic addSample(input int bin, output int newCount);
    histRef[pixelPos][bin] = histRef[pixelPos][bin] + 1;
    newCount = histRef[pixelPos][bin];
    // a tie keeps the bin that got there first
    if (newCount > peakCountRef[pixelPos]) begin
        peakCountRef[pixelPos] = newCount;
        peakBinRef[pixelPos] = bin;
    end
    if (samplePos == histPkg::samplesPerPixel - 1) begin
        samplePos = 0;
        if (pixelPos == histPkg::pixelNum - 1) begin
            pixelPos = 0;
            // last sweep done, frame ends here
            if (acqPos == histPkg::acqNum - 1) begin
                acqPos = 0;
                parityRef = ~parityRef;
            end else begin
                acqPos = acqPos + 1;
            end
        end else begin
            pixelPos = pixelPos + 1;
        end
    end else begin
        samplePos = samplePos + 1;
    end
endtask

// window edges around a peak, kept inside the bin range
function automatic int windowLowFor(input int peak);
    int topBin;
    topBin = histPkg::binNum - 1;
    if (peak < histPkg::windowHalf) begin
        return 0;
    end else if (peak > topBin - histPkg::windowHalf) begin
        return topBin - 2 * histPkg::windowHalf;
    end
    return peak - histPkg::windowHalf;
endfunction

function automatic int windowHighFor(input int peak);
    int topBin;
    topBin = histPkg::binNum - 1;
    if (peak < histPkg::windowHalf) begin
        return 2 * histPkg::windowHalf;
    end else if (peak > topBin - histPkg::windowHalf) begin
        return topBin;
    end
    return peak + histPkg::windowHalf;
endfunction

// ==== bench/histTb.sv ====
`timescale 1ns/10ps

module histTb;

    // cycles allowed between the final sample and peakValid
    localparam int peakTimeout = 16;

    integer seed;
    int mismatchCount;
    int timeoutCount;
    int sequenceCount;

    logic clk;
    logic combin_res;
    logic wrEn;
    histPkg::binIdxT addr;
    histPkg::countT binCount;
    logic countValid;
    logic frameParity;
    logic peakValid;
    histPkg::binIdxT [histPkg::pixelNum-1:0] peakBin;
    histPkg::countT [histPkg::pixelNum-1:0] peakCount;
    histPkg::binIdxT [histPkg::pixelNum-1:0] windowLow;
    histPkg::binIdxT [histPkg::pixelNum-1:0] windowHigh;

    // favoured bin per pixel in directed frames
    int targetBin [histPkg::pixelNum];

    `include "histModel.svh"

    histTop dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .addr        (addr),
        .binCount    (binCount),
        .countValid  (countValid),
        .frameParity (frameParity),
        .peakValid   (peakValid),
        .peakBin     (peakBin),
        .peakCount   (peakCount),
        .windowLow   (windowLow),
        .windowHigh  (windowHigh)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // just past the next rising edge, where inputs change and outputs are settled
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic checkCount(input string name, input histPkg::countT expected,
                              input histPkg::countT actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkBin(input string name, input histPkg::binIdxT expected,
                            input histPkg::binIdxT actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    // one strobe, count comes back the cycle after
    task automatic sendSample(input histPkg::binIdxT bin);
        int newCount;
        wrEn = 1'b1;
        addr = bin;
        addSample(int'(bin), newCount);
        tick();
        wrEn = 1'b0;
        checkBit("countValid", 1'b1, countValid);
        checkCount("binCount", histPkg::countT'(newCount), binCount);
        checkBit("frameParity", parityRef, frameParity);
    endtask

    // wrEn low, addr still wiggling
    task automatic idleCycles(input int n);
        for (int i = 0; i < n; i++) begin
            wrEn = 1'b0;
            addr = histPkg::binIdxT'($random(seed));
            tick();
            checkBit("countValid", 1'b0, countValid);
        end
    endtask

    // drain, then the frame results
    task automatic awaitFrameResults(input bit drainStrobe);
        int edges;
        logic seen;
        edges = 0;
        seen = 1'b0;
        // strobes in the two drain cycles should vanish
        wrEn = drainStrobe;
        addr = histPkg::binIdxT'($random(seed));
        while (!seen && edges < peakTimeout) begin
            tick();
            edges++;
            if (edges <= 2) begin
                checkBit("countValid", 1'b0, countValid);
            end
            if (edges >= 2) begin
                wrEn = 1'b0;
            end
            seen = peakValid;
        end
        wrEn = 1'b0;
        if (!seen) begin
            timeoutCount++;
            $display("peakValid never came within %0d cycles of the frame's last sample", edges);
        end else begin
            if (edges != 2) begin
                sequenceCount++;
                $display("peakValid came %0d edges after the last sample, not 2", edges);
            end
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                checkBin($sformatf("peakBin[%0d]", p),
                         histPkg::binIdxT'(peakBinRef[p]), peakBin[p]);
                checkCount($sformatf("peakCount[%0d]", p),
                           histPkg::countT'(peakCountRef[p]), peakCount[p]);
                checkBin($sformatf("windowLow[%0d]", p),
                         histPkg::binIdxT'(windowLowFor(peakBinRef[p])), windowLow[p]);
                checkBin($sformatf("windowHigh[%0d]", p),
                         histPkg::binIdxT'(windowHighFor(peakBinRef[p])), windowHigh[p]);
            end
            // single-cycle pulse
            tick();
            checkBit("peakValid", 1'b0, peakValid);
        end
    endtask

    // one whole frame, random or steered towards targetBin
    task automatic runFrame(input int frameIdx, input bit directed, input bit drainStrobe);
        int total;
        histPkg::binIdxT bin;
        total = histPkg::pixelNum * histPkg::samplesPerPixel * histPkg::acqNum;
        for (int i = 0; i < total; i++) begin
            // three out of four samples hit the target in directed frames
            if (directed && ($random(seed) & 3) != 0) begin
                bin = histPkg::binIdxT'(targetBin[pixelPos]);
            end else begin
                bin = histPkg::binIdxT'($random(seed));
            end
            sendSample(bin);
            // previous frame must have been wiped
            if (i == 0 && frameIdx > 0) begin
                checkCount("binCount", histPkg::countT'(1), binCount);
            end
            // occasional gaps, never right after the last sample
            if (i < total - 1 && ($random(seed) & 7) == 0) begin
                idleCycles(1 + ($random(seed) & 1));
            end
        end
        awaitFrameResults(drainStrobe);
        clearHistograms();
        idleCycles(3);
    endtask

    initial begin
        seed = 32'he6e9;
        mismatchCount = 0;
        timeoutCount = 0;
        sequenceCount = 0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        addr = '0;
        clearHistograms();
        samplePos = 0;
        pixelPos = 0;
        acqPos = 0;
        parityRef = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        combin_res = 1'b1;
        // quiet and zero out of reset
        checkBit("countValid", 1'b0, countValid);
        checkBit("peakValid", 1'b0, peakValid);
        checkBit("frameParity", 1'b0, frameParity);
        checkCount("binCount", '0, binCount);
        idleCycles(2);
        runFrame(0, 1'b0, 1'b1);
        // peaks at bin 0, the top bin, mid-range and just inside the low clamp
        targetBin = '{0, histPkg::binNum - 1, histPkg::binNum / 2 - 1, 1};
        runFrame(1, 1'b1, 1'b1);
        // edge cases around windowHalf on both sides
        targetBin = '{histPkg::binNum - 2, 2, histPkg::binNum - 3, histPkg::binNum - 1};
        runFrame(2, 1'b1, 1'b0);
        runFrame(3, 1'b0, 1'b1);
        $display("errors: %0d mismatches, %0d timeouts, %0d sequencing",
                 mismatchCount, timeoutCount, sequenceCount);
        if (mismatchCount + timeoutCount + sequenceCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+bench
design/histPkg.sv
design/histSequencer.sv
design/binMemory.sv
design/peakTracker.sv
design/windowCalc.sv
design/histTop.sv
bench/histTb.sv

// ==== Makefile ====
# Verilator build and run of the histogram testbench

TOP       ?= histTb
OBJDIR    ?= obj_dir
VERILATOR ?= verilator
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing -Wno-fatal

PASS_MSG := Simulation completed successfully
SOURCES  := $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
